// ==== vlog.f ====
+incdir+hdl
hdl/udp_tx_pkg.sv
hdl/ip_hdr_reg.sv
hdl/udp_tx_fsm.sv
hdl/axis_skid_reg.sv
hdl/udp_ip_tx.sv
sim/udp_ip_tx_properties.sv
sim/udp_ip_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the udp_ip_tx testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f vlog.f --top-module udp_ip_tx_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vudp_ip_tx_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0

// ==== sim/udp_ip_tx_tb.sv ====
/* testbench for the udp transmit framer: frame table, random back-pressure,
   reference byte model and compare tasks */
`default_nettype none

`include "udp_tx_consts.svh"

module udp_ip_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import udp_tx_pkg::*;

    localparam int N_FRAMES = 8;

    // frame table, one column per array
    port_t    tbl_src_port [N_FRAMES] = '{16'h1234, 16'h0035, 16'hc001, 16'h0007,
                                          16'h8000, 16'hffff, 16'h4321, 16'h0a0b};
    port_t    tbl_dst_port [N_FRAMES] = '{16'h5678, 16'h1f90, 16'h0044, 16'h00a1,
                                          16'h7fff, 16'h0001, 16'h2345, 16'hd00d};
    len_t     tbl_checksum [N_FRAMES] = '{16'hbeef, 16'h0000, 16'h1357, 16'hface,
                                          16'h2468, 16'hffff, 16'h0f0f, 16'ha5a5};
    ttl_t     tbl_ttl      [N_FRAMES] = '{8'h40, 8'h01, 8'h80, 8'hff,
                                          8'h3c, 8'h7f, 8'h10, 8'h22};
    ip_addr_t tbl_src_ip   [N_FRAMES] = '{32'hc0a80001, 32'h0a000001, 32'hac100005,
                                          32'h7f000001, 32'h01020304, 32'hffffffff,
                                          32'hc0a80101, 32'h08080808};
    ip_addr_t tbl_dst_ip   [N_FRAMES] = '{32'hc0a80002, 32'h0a0000fe, 32'hac1000ff,
                                          32'h7f000002, 32'h05060708, 32'h00000000,
                                          32'hc0a801fe, 32'h08080404};
    // udp length counts the 8 header octets
    len_t     tbl_udp_len  [N_FRAMES] = '{16'd16, 16'd13, 16'd20, 16'd9,
                                          16'd10, 16'd30, 16'd40, 16'd24};
    int       tbl_sent     [N_FRAMES] = '{8, 9, 4, 1, 3, 1, 32, 15};
    bit       tbl_stall    [N_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1,
                                          1'b1, 1'b1, 1'b1, 1'b1};

    logic     clk;
    logic     rst;
    logic     s_udp_hdr_valid;
    wire      s_udp_hdr_ready;
    ttl_t     s_ip_ttl;
    ip_addr_t s_ip_source_ip;
    ip_addr_t s_ip_dest_ip;
    port_t    s_udp_source_port;
    port_t    s_udp_dest_port;
    len_t     s_udp_length;
    len_t     s_udp_checksum;
    data_t    s_udp_payload_axis_tdata;
    logic     s_udp_payload_axis_tvalid;
    wire      s_udp_payload_axis_tready;
    logic     s_udp_payload_axis_tlast;
    wire      m_ip_hdr_valid;
    logic     m_ip_hdr_ready = 1'b0;
    len_t     m_ip_length;
    ttl_t     m_ip_ttl;
    ip_addr_t m_ip_source_ip;
    ip_addr_t m_ip_dest_ip;
    data_t    m_ip_payload_axis_tdata;
    wire      m_ip_payload_axis_tvalid;
    logic     m_ip_payload_axis_tready = 1'b0;
    wire      m_ip_payload_axis_tlast;
    wire      m_ip_payload_axis_tuser;
    wire      busy;
    wire      error_payload_early_termination;

    // reference model queues
    data_t    exp_data [$];
    logic     exp_last [$];
    logic     exp_user [$];
    logic     exp_err  [$];
    len_t     exp_len  [$];
    ttl_t     exp_ttl  [$];
    ip_addr_t exp_src  [$];
    ip_addr_t exp_dst  [$];
    data_t    payload  [$];

    bit       stall_en;
    int       cycle_count;
    int       cycle_limit;
    int       bytes_expected;
    int       bytes_seen;
    int       err_pulses;

    udp_ip_tx UUT (.*);

    always #2 clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_byte(input data_t got_data, input data_t want_data,
                              input logic got_last, input logic want_last,
                              input logic got_user, input logic want_user);
        if (got_data !== want_data) begin
            stop_on_failure($sformatf("mismatch m_ip_payload_axis_tdata got %h expected %h byte %0d",
                                      got_data, want_data, bytes_seen));
        end else if (got_last !== want_last) begin
            stop_on_failure($sformatf("mismatch m_ip_payload_axis_tlast got %h expected %h byte %0d",
                                      got_last, want_last, bytes_seen));
        end else if (got_user !== want_user) begin
            stop_on_failure($sformatf("mismatch m_ip_payload_axis_tuser got %h expected %h byte %0d",
                                      got_user, want_user, bytes_seen));
        end
    endtask

    task automatic check_ip_hdr(input len_t got_len, input len_t want_len,
                                input ttl_t got_ttl, input ttl_t want_ttl,
                                input ip_addr_t got_src, input ip_addr_t want_src,
                                input ip_addr_t got_dst, input ip_addr_t want_dst);
        if (got_len !== want_len) begin
            stop_on_failure($sformatf("mismatch m_ip_length got %h expected %h", got_len, want_len));
        end else if (got_ttl !== want_ttl) begin
            stop_on_failure($sformatf("mismatch m_ip_ttl got %h expected %h", got_ttl, want_ttl));
        end else if (got_src !== want_src) begin
            stop_on_failure($sformatf("mismatch m_ip_source_ip got %h expected %h",
                                      got_src, want_src));
        end else if (got_dst !== want_dst) begin
            stop_on_failure($sformatf("mismatch m_ip_dest_ip got %h expected %h",
                                      got_dst, want_dst));
        end
    endtask

    task automatic check_flag(input string name, input int got, input int want);
        if (got !== want) begin
            stop_on_failure($sformatf("mismatch %s got %h expected %h", name, got, want));
        end
    endtask

    function automatic void push_expected(input data_t d, input logic last, input logic user);
        exp_data.push_back(d);
        exp_last.push_back(last);
        exp_user.push_back(user);
    endfunction

    // random payload plus the bytes and ip header this frame must produce
    task automatic build_frame(input int f);
        logic [63:0] hdr_word;
        len_t        keep;
        int          n_out;
        bit          short_frame;
        payload.delete();
        for (int i = 0; i < tbl_sent[f]; i++) begin
            payload.push_back(data_t'($urandom));
        end
        hdr_word = {tbl_src_port[f], tbl_dst_port[f], tbl_udp_len[f], tbl_checksum[f]};
        for (int i = 0; i < `UDP_HDR_BYTES; i++) begin
            push_expected(hdr_word[63 - 8 * i -: 8], 1'b0, 1'b0);
        end
        keep        = tbl_udp_len[f] - len_t'(`UDP_HDR_BYTES);
        short_frame = (tbl_sent[f] < int'(keep));
        n_out       = short_frame ? tbl_sent[f] : int'(keep);
        for (int i = 0; i < n_out; i++) begin
            push_expected(payload[i], i == n_out - 1, short_frame && (i == n_out - 1));
        end
        exp_err.push_back(short_frame);
        exp_len.push_back(tbl_udp_len[f] + len_t'(`IPV4_HDR_BYTES));
        exp_ttl.push_back(tbl_ttl[f]);
        exp_src.push_back(tbl_src_ip[f]);
        exp_dst.push_back(tbl_dst_ip[f]);
        bytes_expected = bytes_expected + `UDP_HDR_BYTES + n_out;
    endtask

    task automatic send_header(input int f);
        @(negedge clk);
        s_udp_hdr_valid   = 1'b1;
        s_ip_ttl          = tbl_ttl[f];
        s_ip_source_ip    = tbl_src_ip[f];
        s_ip_dest_ip      = tbl_dst_ip[f];
        s_udp_source_port = tbl_src_port[f];
        s_udp_dest_port   = tbl_dst_port[f];
        s_udp_length      = tbl_udp_len[f];
        s_udp_checksum    = tbl_checksum[f];
        // ready is registered, so its value now holds for the next rising edge
        while (!s_udp_hdr_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_udp_hdr_valid = 1'b0;
        // FSM leaves idle once the header is taken
        check_flag("busy", busy, 1);
    endtask

    task automatic send_payload();
        int idx;
        bit held;
        idx  = 0;
        held = 1'b0;
        while (idx < payload.size()) begin
            @(negedge clk);
            check_flag("busy", busy, 1);
            if (!held && stall_en && ($urandom % 4 == 0)) begin
                s_udp_payload_axis_tvalid = 1'b0;
            end else begin
                s_udp_payload_axis_tvalid = 1'b1;
                s_udp_payload_axis_tdata  = payload[idx];
                s_udp_payload_axis_tlast  = (idx == payload.size() - 1);
                held = !s_udp_payload_axis_tready;
                if (s_udp_payload_axis_tready) begin
                    idx = idx + 1;
                end
            end
        end
        @(negedge clk);
        s_udp_payload_axis_tvalid = 1'b0;
        s_udp_payload_axis_tlast  = 1'b0;
        // FSM back in idle after the input tlast
        check_flag("busy", busy, 0);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_on_failure($sformatf("timeout: run not finished after %0d cycles", cycle_count));
        end
    end

    // both sinks and the error pulse counter sampled on the falling edge
    always @(negedge clk) begin
        if (error_payload_early_termination) begin
            err_pulses = err_pulses + 1;
        end
        m_ip_hdr_ready           = !stall_en || ($urandom % 2 == 0);
        m_ip_payload_axis_tready = !stall_en || ($urandom % 4 != 0);
        if (m_ip_hdr_valid && m_ip_hdr_ready) begin
            if (exp_len.size() == 0) begin
                stop_on_failure("ip header presented with no frame outstanding");
            end else begin
                check_ip_hdr(m_ip_length, exp_len.pop_front(), m_ip_ttl, exp_ttl.pop_front(),
                             m_ip_source_ip, exp_src.pop_front(),
                             m_ip_dest_ip, exp_dst.pop_front());
            end
        end
        if (m_ip_payload_axis_tvalid && m_ip_payload_axis_tready) begin
            if (exp_data.size() == 0) begin
                stop_on_failure("output byte appeared with no byte expected");
            end else begin
                check_byte(m_ip_payload_axis_tdata, exp_data.pop_front(),
                           m_ip_payload_axis_tlast, exp_last.pop_front(),
                           m_ip_payload_axis_tuser, exp_user.pop_front());
                bytes_seen = bytes_seen + 1;
                if (m_ip_payload_axis_tlast) begin
                    check_flag("error_payload_early_termination pulses", err_pulses,
                               exp_err.pop_front());
                    err_pulses = 0;
                end
            end
        end
    end

    initial begin
        int total;
        void'($urandom(31147));
        clk                       = 1'b0;
        rst                       = 1'b1;
        s_udp_hdr_valid           = 1'b0;
        s_ip_ttl                  = '0;
        s_ip_source_ip            = '0;
        s_ip_dest_ip              = '0;
        s_udp_source_port         = '0;
        s_udp_dest_port           = '0;
        s_udp_length              = '0;
        s_udp_checksum            = '0;
        s_udp_payload_axis_tdata  = '0;
        s_udp_payload_axis_tvalid = 1'b0;
        s_udp_payload_axis_tlast  = 1'b0;
        stall_en                  = 1'b0;
        cycle_count               = 0;
        bytes_expected            = 0;
        bytes_seen                = 0;
        err_pulses                = 0;
        total                     = 0;
        for (int f = 0; f < N_FRAMES; f++) begin
            total = total + `UDP_HDR_BYTES + tbl_sent[f];
        end
        // 40 cycles per table byte plus reset and drain
        cycle_limit = 40 * total + 200;

        repeat (16) @(negedge clk);
        check_flag("s_udp_hdr_ready", s_udp_hdr_ready, 0);
        check_flag("s_udp_payload_axis_tready", s_udp_payload_axis_tready, 0);
        check_flag("m_ip_hdr_valid", m_ip_hdr_valid, 0);
        check_flag("m_ip_payload_axis_tvalid", m_ip_payload_axis_tvalid, 0);
        check_flag("busy", busy, 0);
        check_flag("error_payload_early_termination", error_payload_early_termination, 0);
        rst = 1'b0;

        for (int f = 0; f < N_FRAMES; f++) begin
            stall_en = tbl_stall[f];
            build_frame(f);
            send_header(f);
            send_payload();
        end

        while (exp_data.size() != 0 || exp_len.size() != 0) begin
            @(negedge clk);
        end
        // idle time to catch stray bytes
        repeat (20) @(negedge clk);
        // no error pulse may follow the last frame
        check_flag("error_payload_early_termination pulses", err_pulses, 0);
        if (bytes_seen != bytes_expected) begin
            stop_on_failure($sformatf("%0d output bytes seen but %0d expected",
                                      bytes_seen, bytes_expected));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/udp_ip_tx_properties.sv ====
/* handshake assertions bound into the udp transmit top */
`default_nettype none

module udp_ip_tx_properties (
    input wire                       clk,
    input wire                       rst,
    input wire                       s_udp_hdr_ready,
    input wire                       busy,
    input wire                       m_ip_hdr_valid,
    input wire                       m_ip_hdr_ready,
    input wire udp_tx_pkg::len_t     m_ip_length,
    input wire udp_tx_pkg::ttl_t     m_ip_ttl,
    input wire udp_tx_pkg::ip_addr_t m_ip_source_ip,
    input wire udp_tx_pkg::ip_addr_t m_ip_dest_ip,
    input wire udp_tx_pkg::data_t    m_ip_payload_axis_tdata,
    input wire                       m_ip_payload_axis_tvalid,
    input wire                       m_ip_payload_axis_tready,
    input wire                       m_ip_payload_axis_tlast,
    input wire                       m_ip_payload_axis_tuser
);
    timeunit 1ns;
    timeprecision 100ps;

    // ip header held and stable while the sink stalls
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_ip_hdr_valid && !m_ip_hdr_ready |=> m_ip_hdr_valid && $stable(m_ip_length) &&
            $stable(m_ip_ttl) && $stable(m_ip_source_ip) && $stable(m_ip_dest_ip))
        else $error("ip header dropped or changed while stalled");

    // same for the payload stream
    payload_hold: assert property (@(posedge clk) disable iff (rst)
        m_ip_payload_axis_tvalid && !m_ip_payload_axis_tready |=> m_ip_payload_axis_tvalid &&
            $stable(m_ip_payload_axis_tdata) && $stable(m_ip_payload_axis_tlast) &&
            $stable(m_ip_payload_axis_tuser))
        else $error("payload byte dropped or changed while stalled");

    hdr_ready_idle: assert property (@(posedge clk) disable iff (rst)
        !(s_udp_hdr_ready && busy))
        else $error("header ready raised while a frame is in progress");

endmodule

bind udp_ip_tx udp_ip_tx_properties u_props (.*);

`default_nettype wire

// ==== hdl/udp_ip_tx.sv ====
/* udp transmit framer top: header register, frame FSM, output skid register */
`default_nettype none

module udp_ip_tx (
    input  wire                      clk,
    input  wire                      rst,

    // udp header in
    input  wire                      s_udp_hdr_valid,
    output wire                      s_udp_hdr_ready,
    input  wire udp_tx_pkg::ttl_t    s_ip_ttl,
    input  wire udp_tx_pkg::ip_addr_t s_ip_source_ip,
    input  wire udp_tx_pkg::ip_addr_t s_ip_dest_ip,
    input  wire udp_tx_pkg::port_t   s_udp_source_port,
    input  wire udp_tx_pkg::port_t   s_udp_dest_port,
    input  wire udp_tx_pkg::len_t    s_udp_length,
    input  wire udp_tx_pkg::len_t    s_udp_checksum,

    // udp payload in
    input  wire udp_tx_pkg::data_t   s_udp_payload_axis_tdata,
    input  wire                      s_udp_payload_axis_tvalid,
    output wire                      s_udp_payload_axis_tready,
    input  wire                      s_udp_payload_axis_tlast,

    // ip header out
    output wire                      m_ip_hdr_valid,
    input  wire                      m_ip_hdr_ready,
    output wire udp_tx_pkg::len_t    m_ip_length,
    output wire udp_tx_pkg::ttl_t    m_ip_ttl,
    output wire udp_tx_pkg::ip_addr_t m_ip_source_ip,
    output wire udp_tx_pkg::ip_addr_t m_ip_dest_ip,

    // ip payload out
    output wire udp_tx_pkg::data_t   m_ip_payload_axis_tdata,
    output wire                      m_ip_payload_axis_tvalid,
    input  wire                      m_ip_payload_axis_tready,
    output wire                      m_ip_payload_axis_tlast,
    output wire                      m_ip_payload_axis_tuser,

    // status
    output wire                      busy,
    output wire                      error_payload_early_termination
);
    import udp_tx_pkg::*;

    wire       hdr_store;
    wire       hdr_pending;
    udp_hdr_u  udp_hdr;

    // FSM to skid register stream
    data_t     int_tdata;
    wire       int_tvalid;
    wire       int_tready;
    wire       int_tlast;
    wire       int_tuser;

    ip_hdr_reg u_hdr_reg (
        .clk               (clk),
        .rst               (rst),
        .hdr_store         (hdr_store),
        .s_ip_ttl          (s_ip_ttl),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .s_udp_checksum    (s_udp_checksum),
        .m_ip_hdr_ready    (m_ip_hdr_ready),
        .m_ip_hdr_valid    (m_ip_hdr_valid),
        .m_ip_length       (m_ip_length),
        .m_ip_ttl          (m_ip_ttl),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .udp_hdr           (udp_hdr),
        .hdr_pending       (hdr_pending)
    );

    udp_tx_fsm u_fsm (
        .clk                             (clk),
        .rst                             (rst),
        .s_udp_hdr_valid                 (s_udp_hdr_valid),
        .s_udp_hdr_ready                 (s_udp_hdr_ready),
        .s_udp_payload_axis_tdata        (s_udp_payload_axis_tdata),
        .s_udp_payload_axis_tvalid       (s_udp_payload_axis_tvalid),
        .s_udp_payload_axis_tready       (s_udp_payload_axis_tready),
        .s_udp_payload_axis_tlast        (s_udp_payload_axis_tlast),
        .udp_hdr                         (udp_hdr),
        .hdr_pending                     (hdr_pending),
        .hdr_store                       (hdr_store),
        .int_tdata                       (int_tdata),
        .int_tvalid                      (int_tvalid),
        .int_tready                      (int_tready),
        .int_tlast                       (int_tlast),
        .int_tuser                       (int_tuser),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    axis_skid_reg u_out_reg (
        .clk        (clk),
        .rst        (rst),
        .int_tdata  (int_tdata),
        .int_tvalid (int_tvalid),
        .int_tlast  (int_tlast),
        .int_tuser  (int_tuser),
        .int_tready (int_tready),
        .m_tready   (m_ip_payload_axis_tready),
        .m_tdata    (m_ip_payload_axis_tdata),
        .m_tvalid   (m_ip_payload_axis_tvalid),
        .m_tlast    (m_ip_payload_axis_tlast),
        .m_tuser    (m_ip_payload_axis_tuser)
    );

endmodule

`default_nettype wire

// ==== hdl/axis_skid_reg.sv ====
/* two-entry output register for the payload stream, registered early ready */
`default_nettype none

module axis_skid_reg (
    input  wire                    clk,
    input  wire                    rst,
    input  wire udp_tx_pkg::data_t int_tdata,
    input  wire                    int_tvalid,
    input  wire                    int_tlast,
    input  wire                    int_tuser,
    output logic                   int_tready,
    input  wire                    m_tready,
    output udp_tx_pkg::data_t      m_tdata,
    output logic                   m_tvalid,
    output logic                   m_tlast,
    output logic                   m_tuser
);
    import udp_tx_pkg::*;

    logic  m_tvalid_next;
    data_t temp_tdata;
    logic  temp_tvalid;
    logic  temp_tvalid_next;
    logic  temp_tlast;
    logic  temp_tuser;
    logic  tready_early;
    logic  int_to_out;
    logic  int_to_temp;
    logic  temp_to_out;

    // ready next cycle if sink takes data, or temp stays empty
    assign tready_early = m_tready || (!temp_tvalid && (!m_tvalid || !int_tvalid));

    always_comb begin
        m_tvalid_next    = m_tvalid;
        temp_tvalid_next = temp_tvalid;
        int_to_out       = 1'b0;
        int_to_temp      = 1'b0;
        temp_to_out      = 1'b0;

        if (int_tready) begin
            if (m_tready || !m_tvalid) begin
                m_tvalid_next = int_tvalid;
                int_to_out    = 1'b1;
            end else begin
                // sink stalled, park the byte
                temp_tvalid_next = int_tvalid;
                int_to_temp      = 1'b1;
            end
        end else if (m_tready) begin
            m_tvalid_next    = temp_tvalid;
            temp_tvalid_next = 1'b0;
            temp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid    <= 1'b0;
            temp_tvalid <= 1'b0;
            int_tready  <= 1'b0;
        end else begin
            m_tvalid    <= m_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
            int_tready  <= tready_early;
        end

        if (int_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (temp_to_out) begin
            m_tdata <= temp_tdata;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end

        if (int_to_temp) begin
            temp_tdata <= int_tdata;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_tx_fsm.sv ====
/* frame FSM: udp header serialization, payload forwarding, trimming and short-frame flag */
`default_nettype none

`include "udp_tx_consts.svh"

module udp_tx_fsm (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       s_udp_hdr_valid,
    output logic                      s_udp_hdr_ready,
    input  wire udp_tx_pkg::data_t    s_udp_payload_axis_tdata,
    input  wire                       s_udp_payload_axis_tvalid,
    output logic                      s_udp_payload_axis_tready,
    input  wire                       s_udp_payload_axis_tlast,
    input  wire udp_tx_pkg::udp_hdr_u udp_hdr,
    input  wire                       hdr_pending,
    output logic                      hdr_store,
    output udp_tx_pkg::data_t         int_tdata,
    output logic                      int_tvalid,
    input  wire                       int_tready,
    output logic                      int_tlast,
    output logic                      int_tuser,
    output logic                      busy,
    output logic                      error_payload_early_termination
);
    import udp_tx_pkg::*;

    localparam logic [1:0] ST_IDLE         = 2'd0;
    localparam logic [1:0] ST_HEADER       = 2'd1;
    localparam logic [1:0] ST_PAYLOAD      = 2'd2;
    localparam logic [1:0] ST_PAYLOAD_LAST = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;
    len_t       frame_ptr;
    len_t       frame_ptr_next;
    logic       hdr_ready_next;
    logic       error_next;
    logic       store_last;
    data_t      last_data;
    logic       in_xfer;

    // payload input follows the registered early ready of the output stage
    assign s_udp_payload_axis_tready = int_tready &&
        (state == ST_PAYLOAD || state == ST_PAYLOAD_LAST);
    assign in_xfer = s_udp_payload_axis_tready && s_udp_payload_axis_tvalid;
    assign busy = (state != ST_IDLE);

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        hdr_ready_next = 1'b0;
        hdr_store      = 1'b0;
        store_last     = 1'b0;
        error_next     = 1'b0;
        int_tdata      = s_udp_payload_axis_tdata;
        int_tvalid     = 1'b0;
        int_tlast      = 1'b0;
        int_tuser      = 1'b0;

        case (state)
            ST_IDLE: begin
                frame_ptr_next = '0;
                hdr_ready_next = !hdr_pending;
                if (s_udp_hdr_ready && s_udp_hdr_valid) begin
                    hdr_store      = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next     = ST_HEADER;
                end
            end
            ST_HEADER: begin
                // low pointer bits pick the header octet
                int_tdata  = udp_hdr.octets[frame_ptr[2:0]];
                int_tvalid = 1'b1;
                if (int_tready) begin
                    frame_ptr_next = frame_ptr + 1'b1;
                    if (frame_ptr == len_t'(`UDP_HDR_BYTES - 1)) begin
                        state_next = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                int_tvalid = s_udp_payload_axis_tvalid;
                int_tlast  = s_udp_payload_axis_tlast;
                if (in_xfer) begin
                    frame_ptr_next = frame_ptr + 1'b1;
                    if (s_udp_payload_axis_tlast) begin
                        // input ended before the udp length was reached
                        if (frame_ptr_next != udp_hdr.fields.length) begin
                            int_tuser  = 1'b1;
                            error_next = 1'b1;
                        end
                        hdr_ready_next = !hdr_pending;
                        state_next     = ST_IDLE;
                    end else if (frame_ptr_next == udp_hdr.fields.length) begin
                        // hold the final byte until the input frame ends
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = ST_PAYLOAD_LAST;
                    end
                end
            end
            ST_PAYLOAD_LAST: begin
                // excess bytes are dropped, held byte goes out on tlast
                int_tdata  = last_data;
                int_tvalid = s_udp_payload_axis_tvalid && s_udp_payload_axis_tlast;
                int_tlast  = s_udp_payload_axis_tlast;
                if (in_xfer && s_udp_payload_axis_tlast) begin
                    hdr_ready_next = !hdr_pending;
                    state_next     = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                           <= ST_IDLE;
            frame_ptr                       <= '0;
            s_udp_hdr_ready                 <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            frame_ptr                       <= frame_ptr_next;
            s_udp_hdr_ready                 <= hdr_ready_next;
            error_payload_early_termination <= error_next;
        end

        if (store_last) begin
            last_data <= s_udp_payload_axis_tdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ip_hdr_reg.sv ====
/* header field capture, ip length computation and ip header valid/ready */
`default_nettype none

`include "udp_tx_consts.svh"

module ip_hdr_reg (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       hdr_store,
    input  wire udp_tx_pkg::ttl_t     s_ip_ttl,
    input  wire udp_tx_pkg::ip_addr_t s_ip_source_ip,
    input  wire udp_tx_pkg::ip_addr_t s_ip_dest_ip,
    input  wire udp_tx_pkg::port_t    s_udp_source_port,
    input  wire udp_tx_pkg::port_t    s_udp_dest_port,
    input  wire udp_tx_pkg::len_t     s_udp_length,
    input  wire udp_tx_pkg::len_t     s_udp_checksum,
    input  wire                       m_ip_hdr_ready,
    output logic                      m_ip_hdr_valid,
    output udp_tx_pkg::len_t          m_ip_length,
    output udp_tx_pkg::ttl_t          m_ip_ttl,
    output udp_tx_pkg::ip_addr_t      m_ip_source_ip,
    output udp_tx_pkg::ip_addr_t      m_ip_dest_ip,
    output udp_tx_pkg::udp_hdr_u      udp_hdr,
    output logic                      hdr_pending
);
    import udp_tx_pkg::*;

    // FSM holds off the next header while this one is unsent
    assign hdr_pending = m_ip_hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_ip_hdr_valid <= 1'b0;
        end else if (hdr_store) begin
            m_ip_hdr_valid <= 1'b1;
        end else if (m_ip_hdr_ready) begin
            m_ip_hdr_valid <= 1'b0;
        end

        if (hdr_store) begin
            // ip total length covers the udp frame plus the ipv4 header
            m_ip_length    <= s_udp_length + len_t'(`IPV4_HDR_BYTES);
            m_ip_ttl       <= s_ip_ttl;
            m_ip_source_ip <= s_ip_source_ip;
            m_ip_dest_ip   <= s_ip_dest_ip;

            udp_hdr.fields.source_port <= s_udp_source_port;
            udp_hdr.fields.dest_port   <= s_udp_dest_port;
            udp_hdr.fields.length      <= s_udp_length;
            udp_hdr.fields.checksum    <= s_udp_checksum;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/udp_tx_pkg.sv ====
/* shared stream, length, port and address types, udp header union */
`default_nettype none

`include "udp_tx_consts.svh"

package udp_tx_pkg;

    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [`LEN_W-1:0]     len_t;
    typedef logic [`PORT_W-1:0]    port_t;
    typedef logic [`IP_ADDR_W-1:0] ip_addr_t;
    typedef logic [`TTL_W-1:0]     ttl_t;

    // same 64 bits seen as header fields or as wire octets
    // octet 0 is the msb, first on the wire
    typedef union packed {
        struct packed {
            port_t source_port;
            port_t dest_port;
            len_t  length;
            len_t  checksum;
        } fields;
        data_t [0:`UDP_HDR_BYTES-1] octets;
    } udp_hdr_u;

endpackage

`default_nettype wire

// ==== hdl/udp_tx_consts.svh ====
/* widths and header sizes for the udp transmit path */
`ifndef UDP_TX_CONSTS_SVH
`define UDP_TX_CONSTS_SVH

// datapath and field widths
`define DATA_W 8
`define LEN_W 16
`define PORT_W 16
`define IP_ADDR_W 32
`define TTL_W 8

// header sizes in octets
`define UDP_HDR_BYTES 8

// ipv4 header without options
`define IPV4_HDR_BYTES 20

`endif
